// ==== verilog/sb_ism_pkg.sv ====
// ====================
// Shared state encodings and delay width for the sideband agent ISM
// Import into module bodies; use scoped names in port lists
// ====================
package sb_ism_pkg;

  // ====================
  // Clock-gate delay
  // ====================
  localparam int CG_DELAY_W = 4;        // Width of the delay strap and the timer count

  // ====================
  // Agent ISM states
  // ====================
  // Driven by the agent on ism_out
  typedef enum logic [2:0] {
    AGENT_IDLE       = 3'b000,          // Link idle, clocks may be gated
    AGENT_ACTIVEREQ  = 3'b001,          // Agent asks to go active
    AGENT_IDLEREQ    = 3'b010,          // Agent asks to go idle
    AGENT_ACTIVE     = 3'b011,          // Link active
    AGENT_CREDITREQ  = 3'b100,          // Agent asks for credit init
    AGENT_CREDITINIT = 3'b101,          // Credits being exchanged
    AGENT_CREDITDONE = 3'b110           // Agent finished credit init
  } agent_state_e;

  // ====================
  // Fabric ISM states
  // ====================
  // Seen by the agent on ism_in
  // 3'b111 is unused on both sides
  typedef enum logic [2:0] {
    FABRIC_IDLE       = 3'b000,
    FABRIC_ACTIVEREQ  = 3'b001,         // Fabric requests or acks ACTIVE
    FABRIC_IDLENAK    = 3'b010,         // Fabric refuses the idle request
    FABRIC_ACTIVE     = 3'b011,
    FABRIC_CREDITREQ  = 3'b100,         // Fabric asks for credit init
    FABRIC_CREDITINIT = 3'b101,
    FABRIC_CREDITACK  = 3'b110          // Fabric acks the agent credit request
  } fabric_state_e;

endpackage

// ==== verilog/cg_delay_timer.sv ====
// ====================
// Clock-gate delay counter that holds off every exit from IDLE
// Reloads while idle, counts down while an exit is pending
// ====================
`timescale 1ns/1ps

module cg_delay_timer #(
  parameter int unsigned CG_DELAY          = 0,     // Delay used without the strap
  parameter bit          CG_DELAY_STRAP_EN = 1'b0   // Take the delay from the strap
) (
  input  logic                              clk,
  input  logic                              rst_b,
  input  logic [sb_ism_pkg::CG_DELAY_W-1:0] cg_delay_strap,  // Strapped delay in cycles
  input  logic                              cg_count_en,     // Exit pending in IDLE
  output logic                              cg_ready         // Delay has run out
);
  import sb_ism_pkg::*;

  logic [CG_DELAY_W-1:0] delay;         // Selected reload value
  logic [CG_DELAY_W-1:0] count;         // Cycles left before an exit may happen

  // Delay source select, fixed at build time
  always_comb begin
    if (CG_DELAY_STRAP_EN) begin
      delay = cg_delay_strap;
    end else begin
      delay = CG_DELAY_W'(CG_DELAY);    // Upper bits of CG_DELAY are dropped
    end
  end

  // ====================
  // Counter
  // ====================
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      count <= '0;
    end else if (!cg_count_en) begin
      count <= delay;                   // No exit pending, keep armed with the full delay
    end else if (count != '0) begin
      count <= count - 1'b1;            // Exit pending, count toward zero
    end
  end

  assign cg_ready = (count == '0);      // Zero delay lets the exit through at once

  // Count only moves down while counting, so it never wraps from zero
  a_count_no_wrap : assert property (@(posedge clk) disable iff (!rst_b)
    cg_count_en |=> (count <= $past(count)))
    else $error("cg_delay_timer count wrapped below zero");

endmodule

// ==== verilog/sb_agent_ism.sv ====
// ====================
// Agent side sideband clock-gating ISM with credit init flow
// Drives ism_out and the local clock-gate enable, steered by cg_delay_timer
// ====================
`timescale 1ns/1ps

module sb_agent_ism #(
  parameter bit SKIP_ACTIVEREQ = 1'b0   // IDLE may jump to ACTIVE on fabric ACTIVEREQ
) (
  input  logic                      clk,
  input  logic                      rst_b,
  input  logic                      int_pok,          // Link partner powered and ok
  input  logic                      port_disable,     // Keeps the ISM parked in IDLE
  input  logic                      side_ism_lock_b,  // Lock open when high
  input  logic                      side_clk_valid,   // Side clock is running
  input  logic                      ip_wake,          // Local wake event
  input  logic                      idle,             // Local idle limit reached
  input  logic                      init_done,        // Local credit init finished
  input  sb_ism_pkg::fabric_state_e ism_in,           // Fabric ISM state
  input  logic                      cg_ready,         // Clock-gate delay ran out
  output logic                      cg_count_en,      // Exit pending, run the delay
  output sb_ism_pkg::agent_state_e  ism_out,          // Agent ISM state
  output logic                      cg_en,            // Clock-gate enable to local gate
  output logic                      credit_reinit     // Credit counters need init
);
  import sb_ism_pkg::*;

  agent_state_e ism_nxt;
  logic         cg_en_nxt;
  logic         reinit_nxt;
  logic         credit_exit;            // IDLE to CREDITREQ wanted
  logic         active_exit;            // IDLE to ACTIVEREQ or ACTIVE wanted

  // ====================
  // IDLE exit conditions
  // ====================
  // Credit request from the fabric, or our own pending reinit once the clock is up
  always_comb begin
    credit_exit = int_pok && side_ism_lock_b &&
                  ((ism_in == FABRIC_CREDITREQ) || (credit_reinit && side_clk_valid));
  end

  // Wake only after credits are set up
  always_comb begin
    active_exit = int_pok && !credit_reinit && side_ism_lock_b &&
                  ((ism_in == FABRIC_ACTIVEREQ) ||
                   (ip_wake && (ism_in == FABRIC_IDLE) && side_clk_valid));
  end

  // Timer runs only while an exit is actually being taken
  assign cg_count_en = (ism_out == AGENT_IDLE) && !port_disable &&
                       (credit_exit || active_exit);

  // ====================
  // Next state
  // ====================
  always_comb begin
    ism_nxt    = ism_out;               // Hold unless a transition fires
    cg_en_nxt  = cg_en;
    reinit_nxt = credit_reinit;

    case (ism_out)
      AGENT_IDLE: begin
        if (port_disable) begin
          ism_nxt = AGENT_IDLE;         // Port off, no exit at all
        end else if (credit_exit) begin
          cg_en_nxt = 1'b1;             // Open the clock gate while the delay runs
          if (cg_ready) begin
            ism_nxt = AGENT_CREDITREQ;
          end
        end else if (active_exit) begin
          cg_en_nxt = 1'b1;
          if (cg_ready) begin
            // Fabric already asking, skip our own request if allowed
            if (SKIP_ACTIVEREQ && (ism_in == FABRIC_ACTIVEREQ)) begin
              ism_nxt = AGENT_ACTIVE;
            end else begin
              ism_nxt = AGENT_ACTIVEREQ;
            end
          end
        end
      end

      AGENT_ACTIVEREQ: begin
        if (!int_pok) begin
          ism_nxt   = AGENT_IDLE;       // Partner lost power, fall back
          cg_en_nxt = 1'b0;
        end else if (ism_in == FABRIC_ACTIVEREQ) begin
          ism_nxt = AGENT_ACTIVE;
        end else if (ism_in == FABRIC_CREDITREQ) begin
          ism_nxt = AGENT_CREDITREQ;    // Fabric wants credits first
        end
      end

      AGENT_ACTIVE: begin
        if (idle && (ism_in == FABRIC_ACTIVE) && side_clk_valid) begin
          ism_nxt = AGENT_IDLEREQ;
        end
      end

      AGENT_IDLEREQ: begin
        if (ism_in == FABRIC_IDLE) begin
          ism_nxt   = AGENT_IDLE;
          cg_en_nxt = 1'b0;             // Back in IDLE, gate may close
        end else if (ism_in == FABRIC_IDLENAK) begin
          ism_nxt = AGENT_ACTIVE;       // Fabric refused, stay up
        end
      end

      AGENT_CREDITREQ: begin
        if (!int_pok) begin
          ism_nxt   = AGENT_IDLE;
          cg_en_nxt = 1'b0;
        end else if (ism_in == FABRIC_CREDITACK) begin
          ism_nxt    = AGENT_CREDITINIT;
          reinit_nxt = 1'b1;            // Flag local counters for the fabric-led case too
        end
      end

      AGENT_CREDITINIT: begin
        reinit_nxt = 1'b0;              // Counters are being set up now
        if (init_done && (ism_in == FABRIC_CREDITINIT) && side_clk_valid) begin
          ism_nxt = AGENT_CREDITDONE;
        end
      end

      AGENT_CREDITDONE: begin
        if (ism_in == FABRIC_IDLE) begin
          ism_nxt   = AGENT_IDLE;
          cg_en_nxt = 1'b0;
        end
      end

      default: begin
        ism_nxt   = AGENT_IDLE;         // Unused code, recover to IDLE
        cg_en_nxt = 1'b0;
      end
    endcase
  end

  // ====================
  // State registers
  // ====================
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      ism_out       <= AGENT_IDLE;
      cg_en         <= 1'b0;
      credit_reinit <= 1'b1;            // Credits always set up after reset
    end else begin
      ism_out       <= ism_nxt;
      cg_en         <= cg_en_nxt;
      credit_reinit <= reinit_nxt;
    end
  end

  // ====================
  // Assertions
  // ====================
  a_state_legal : assert property (@(posedge clk) disable iff (!rst_b)
    ism_out inside {AGENT_IDLE, AGENT_ACTIVEREQ, AGENT_IDLEREQ, AGENT_ACTIVE,
                    AGENT_CREDITREQ, AGENT_CREDITINIT, AGENT_CREDITDONE})
    else $error("Agent ISM in illegal state %b", ism_out);

  // ACTIVEREQ has a single entry arc
  a_activereq_from_idle : assert property (@(posedge clk) disable iff (!rst_b)
    ($changed(ism_out) && (ism_out == AGENT_ACTIVEREQ)) |-> ($past(ism_out) == AGENT_IDLE))
    else $error("ACTIVEREQ entered from %b", $past(ism_out));

  a_creditdone_from_init : assert property (@(posedge clk) disable iff (!rst_b)
    ($changed(ism_out) && (ism_out == AGENT_CREDITDONE)) |->
      ($past(ism_out) == AGENT_CREDITINIT))
    else $error("CREDITDONE entered from %b", $past(ism_out));

  // Disabled port never leaves IDLE
  a_port_disable_idle : assert property (@(posedge clk) disable iff (!rst_b)
    (port_disable && (ism_out == AGENT_IDLE)) |=> (ism_out == AGENT_IDLE))
    else $error("ISM left IDLE while port_disable was held");

endmodule

// ==== verilog/sb_agent_port.sv ====
// ====================
// Agent sideband port top with the ISM and its clock-gate delay timer
// Parameters set here reach both blocks
// ====================
`timescale 1ns/1ps

module sb_agent_port #(
  parameter int unsigned CG_DELAY          = 0,     // Delay when the strap is off
  parameter bit          CG_DELAY_STRAP_EN = 1'b0,  // Delay from cg_delay_strap
  parameter bit          SKIP_ACTIVEREQ    = 1'b0   // Allow IDLE straight to ACTIVE
) (
  input  logic                              clk,
  input  logic                              rst_b,
  // Qualifiers
  input  logic                              int_pok,
  input  logic                              port_disable,
  input  logic                              side_ism_lock_b,
  input  logic                              side_clk_valid,
  // Local agent events
  input  logic                              ip_wake,
  input  logic                              idle,
  input  logic                              init_done,
  input  logic [sb_ism_pkg::CG_DELAY_W-1:0] cg_delay_strap,
  // Link handshake
  input  sb_ism_pkg::fabric_state_e         ism_in,
  output sb_ism_pkg::agent_state_e          ism_out,
  // Local controls
  output logic                              cg_en,
  output logic                              credit_reinit
);

  logic cg_count_en;                    // ISM exit pending
  logic cg_ready;                       // Delay expired

  // ====================
  // Delay timer
  // ====================
  cg_delay_timer #(
    .CG_DELAY          (CG_DELAY),
    .CG_DELAY_STRAP_EN (CG_DELAY_STRAP_EN)
  ) cg_delay_timer_inst (
    .clk            (clk),
    .rst_b          (rst_b),
    .cg_delay_strap (cg_delay_strap),
    .cg_count_en    (cg_count_en),
    .cg_ready       (cg_ready)
  );

  // ====================
  // Agent ISM
  // ====================
  sb_agent_ism #(
    .SKIP_ACTIVEREQ (SKIP_ACTIVEREQ)
  ) sb_agent_ism_inst (
    .clk             (clk),
    .rst_b           (rst_b),
    .int_pok         (int_pok),
    .port_disable    (port_disable),
    .side_ism_lock_b (side_ism_lock_b),
    .side_clk_valid  (side_clk_valid),
    .ip_wake         (ip_wake),
    .idle            (idle),
    .init_done       (init_done),
    .ism_in          (ism_in),
    .cg_ready        (cg_ready),
    .cg_count_en     (cg_count_en),
    .ism_out         (ism_out),
    .cg_en           (cg_en),
    .credit_reinit   (credit_reinit)
  );

endmodule

// ==== verif/fabric_ism_model.sv ====
// ====================
// Behavioural fabric ISM that answers the agent state on the link
// nak refuses idle requests, stall holds off the ACTIVEREQ answer
// ====================
`timescale 1ns/1ps

module fabric_ism_model (
  input  logic                      clk,
  input  logic                      rst_b,
  input  sb_ism_pkg::agent_state_e  agent_state,   // Agent ism_out
  input  logic                      nak,           // Answer IDLEREQ with IDLENAK
  input  logic                      stall,         // Leave agent ACTIVEREQ unanswered
  output sb_ism_pkg::fabric_state_e fabric_state   // Drives agent ism_in
);
  import sb_ism_pkg::*;

  fabric_state_e state_nxt;

  always_comb begin
    state_nxt = fabric_state;           // Hold until the agent moves
    case (fabric_state)
      FABRIC_IDLE: begin
        if (agent_state == AGENT_CREDITREQ) begin
          state_nxt = FABRIC_CREDITACK;
        end else if ((agent_state == AGENT_ACTIVEREQ) && !stall) begin
          state_nxt = FABRIC_ACTIVEREQ;
        end
      end
      FABRIC_CREDITACK: begin
        if (agent_state == AGENT_CREDITINIT) begin
          state_nxt = FABRIC_CREDITINIT;
        end else if (agent_state == AGENT_IDLE) begin
          state_nxt = FABRIC_IDLE;      // Agent fell back on power loss
        end
      end
      FABRIC_CREDITINIT: begin
        if (agent_state == AGENT_CREDITDONE) begin
          state_nxt = FABRIC_IDLE;
        end
      end
      FABRIC_ACTIVEREQ: begin
        if (agent_state == AGENT_ACTIVE) begin
          state_nxt = FABRIC_ACTIVE;
        end else if (agent_state == AGENT_IDLE) begin
          state_nxt = FABRIC_IDLE;
        end
      end
      FABRIC_ACTIVE: begin
        if (agent_state == AGENT_IDLEREQ) begin
          state_nxt = nak ? FABRIC_IDLENAK : FABRIC_IDLE;
        end
      end
      FABRIC_IDLENAK: begin
        if (agent_state == AGENT_ACTIVE) begin
          state_nxt = FABRIC_ACTIVE;    // Agent took the NAK
        end
      end
      default: begin
        state_nxt = FABRIC_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      fabric_state <= FABRIC_IDLE;
    end else begin
      fabric_state <= state_nxt;
    end
  end

endmodule

// ==== verif/tb_sb_agent_port.sv ====
// ====================
// Testbench for the agent sideband port with a fabric model on the link
// Concurrent assertions check, the stimulus walks each ISM flow
// ====================
`timescale 1ns/1ps

module tb_sb_agent_port;
  import sb_ism_pkg::*;

  localparam int          RESET_CYCLES = 16;
  localparam logic [31:0] LCG_SEED     = 32'h5942cb1c;
  localparam int          EXIT_WAIT    = 40;    // Longest strap delay plus margin
  localparam int          STEP_WAIT    = 20;    // One link handshake

  logic                  clk;
  logic                  rst_b;
  logic                  int_pok;
  logic                  port_disable;
  logic                  side_ism_lock_b;
  logic                  side_clk_valid;
  logic                  ip_wake;
  logic                  idle;
  logic                  init_done;
  logic [CG_DELAY_W-1:0] strap;
  fabric_state_e         ism_in;
  agent_state_e          ism_out;
  logic                  cg_en;
  logic                  credit_reinit;
  logic                  nak;
  logic                  stall;
  logic [31:0]           seed;
  int                    errors = 0;
  int                    timeouts = 0;
  int                    run_cnt;               // Edges an IDLE exit has been held
  logic                  credit_go;
  logic                  active_go;
  logic                  exit_now;

  always #2 clk = ~clk;                         // 4 ns period

  sb_agent_port #(
    .CG_DELAY          (0),
    .CG_DELAY_STRAP_EN (1'b1),
    .SKIP_ACTIVEREQ    (1'b0)
  ) sb_agent_port_inst (
    .clk (clk), .rst_b (rst_b), .int_pok (int_pok), .port_disable (port_disable),
    .side_ism_lock_b (side_ism_lock_b), .side_clk_valid (side_clk_valid),
    .ip_wake (ip_wake), .idle (idle), .init_done (init_done), .cg_delay_strap (strap),
    .ism_in (ism_in), .ism_out (ism_out), .cg_en (cg_en), .credit_reinit (credit_reinit)
  );

  fabric_ism_model fabric_ism_model_inst (
    .clk (clk), .rst_b (rst_b), .agent_state (ism_out), .nak (nak), .stall (stall),
    .fabric_state (ism_in)
  );

  // ====================
  // Expected IDLE exits
  // ====================
  assign credit_go = int_pok && side_ism_lock_b &&
                     ((ism_in == FABRIC_CREDITREQ) || (credit_reinit && side_clk_valid));
  assign active_go = int_pok && !credit_reinit && side_ism_lock_b &&
                     ((ism_in == FABRIC_ACTIVEREQ) ||
                      (ip_wake && (ism_in == FABRIC_IDLE) && side_clk_valid));
  assign exit_now  = (ism_out == AGENT_IDLE) && !port_disable && (credit_go || active_go);

  always @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      run_cnt <= 0;
    end else if (exit_now) begin
      run_cnt <= run_cnt + 1;
    end else begin
      run_cnt <= 0;                             // Exit dropped or taken
    end
  end

  task automatic report_value(input string name, input int exp, input int got);
    errors++;
    $display("error %0t %s expected %0h got %0h", $time, name, exp, got);
  endtask

  // ====================
  // Checks
  // ====================
  a_reset_outputs : assert property (@(posedge clk) (!rst_b || $rose(rst_b)) |->
    ((ism_out == AGENT_IDLE) && !cg_en && credit_reinit))
    else begin
      errors++;
      $display("error %0t reset ism_out cg_en credit_reinit expected 0 0 1 got %0h %0b %0b",
               $time, ism_out, cg_en, credit_reinit);
    end
  a_cg_en_on_exit : assert property (@(posedge clk) disable iff (!rst_b)
    exit_now |=> cg_en) else report_value("cg_en", 1, int'(cg_en));
  // Exit held off until the strap delay has run down
  a_exit_held_off : assert property (@(posedge clk) disable iff (!rst_b)
    (exit_now && (run_cnt < int'(strap))) |=> (ism_out == AGENT_IDLE))
    else report_value("ism_out", int'(AGENT_IDLE), int'(ism_out));
  a_credit_exit : assert property (@(posedge clk) disable iff (!rst_b)
    (exit_now && credit_go && (run_cnt == int'(strap))) |=> (ism_out == AGENT_CREDITREQ))
    else report_value("ism_out", int'(AGENT_CREDITREQ), int'(ism_out));
  a_active_exit : assert property (@(posedge clk) disable iff (!rst_b)
    (exit_now && !credit_go && (run_cnt == int'(strap))) |=> (ism_out == AGENT_ACTIVEREQ))
    else report_value("ism_out", int'(AGENT_ACTIVEREQ), int'(ism_out));
  a_creditreq_ack : assert property (@(posedge clk) disable iff (!rst_b)
    ((ism_out == AGENT_CREDITREQ) && int_pok && (ism_in == FABRIC_CREDITACK)) |=>
      (ism_out == AGENT_CREDITINIT))
    else report_value("ism_out", int'(AGENT_CREDITINIT), int'(ism_out));
  a_reinit_cleared : assert property (@(posedge clk) disable iff (!rst_b)
    (ism_out == AGENT_CREDITINIT) |=> !credit_reinit)
    else report_value("credit_reinit", 0, int'(credit_reinit));
  a_creditinit_done : assert property (@(posedge clk) disable iff (!rst_b)
    ((ism_out == AGENT_CREDITINIT) && init_done && (ism_in == FABRIC_CREDITINIT) &&
     side_clk_valid) |=> (ism_out == AGENT_CREDITDONE))
    else report_value("ism_out", int'(AGENT_CREDITDONE), int'(ism_out));
  a_creditdone_idle : assert property (@(posedge clk) disable iff (!rst_b)
    ((ism_out == AGENT_CREDITDONE) && (ism_in == FABRIC_IDLE)) |=> (ism_out == AGENT_IDLE))
    else report_value("ism_out", int'(AGENT_IDLE), int'(ism_out));
  a_activereq_active : assert property (@(posedge clk) disable iff (!rst_b)
    ((ism_out == AGENT_ACTIVEREQ) && int_pok && (ism_in == FABRIC_ACTIVEREQ)) |=>
      (ism_out == AGENT_ACTIVE))
    else report_value("ism_out", int'(AGENT_ACTIVE), int'(ism_out));
  a_active_idlereq : assert property (@(posedge clk) disable iff (!rst_b)
    ((ism_out == AGENT_ACTIVE) && idle && (ism_in == FABRIC_ACTIVE) && side_clk_valid) |=>
      (ism_out == AGENT_IDLEREQ))
    else report_value("ism_out", int'(AGENT_IDLEREQ), int'(ism_out));
  a_idlereq_idle : assert property (@(posedge clk) disable iff (!rst_b)
    ((ism_out == AGENT_IDLEREQ) && (ism_in == FABRIC_IDLE)) |=> (ism_out == AGENT_IDLE))
    else report_value("ism_out", int'(AGENT_IDLE), int'(ism_out));
  a_idlereq_nak : assert property (@(posedge clk) disable iff (!rst_b)
    ((ism_out == AGENT_IDLEREQ) && (ism_in == FABRIC_IDLENAK)) |=> (ism_out == AGENT_ACTIVE))
    else report_value("ism_out", int'(AGENT_ACTIVE), int'(ism_out));
  a_nak_no_idle : assert property (@(posedge clk) disable iff (!rst_b)
    (nak && (ism_out == AGENT_IDLEREQ)) |=> (ism_out != AGENT_IDLE))
    else begin
      errors++;
      $display("error %0t ism_out expected not %0h got %0h", $time, AGENT_IDLE, ism_out);
    end
  a_idle_gate_closed : assert property (@(posedge clk) disable iff (!rst_b)
    ((ism_out == AGENT_IDLE) && ($past(ism_out) != AGENT_IDLE)) |-> !cg_en)
    else report_value("cg_en", 0, int'(cg_en));
  a_holdoff : assert property (@(posedge clk) disable iff (!rst_b)
    ((ism_out == AGENT_IDLE) && (port_disable || !side_ism_lock_b)) |=>
      (ism_out == AGENT_IDLE))
    else report_value("ism_out", int'(AGENT_IDLE), int'(ism_out));
  // Power loss while a request is pending
  a_pok_fallback : assert property (@(posedge clk) disable iff (!rst_b)
    (((ism_out == AGENT_ACTIVEREQ) || (ism_out == AGENT_CREDITREQ)) && !int_pok) |=>
      (ism_out == AGENT_IDLE))
    else report_value("ism_out", int'(AGENT_IDLE), int'(ism_out));
  a_pok_gate_closed : assert property (@(posedge clk) disable iff (!rst_b)
    (((ism_out == AGENT_ACTIVEREQ) || (ism_out == AGENT_CREDITREQ)) && !int_pok) |=> !cg_en)
    else report_value("cg_en", 0, int'(cg_en));

  // ====================
  // Stimulus helpers
  // ====================
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic step(input int n);
    repeat (n) begin
      @(posedge clk);
      #0.5;                                     // Drive point after the edge
    end
  endtask

  // New strap, one edge so the timer reloads it
  task automatic pick_delay();
    seed  = lcg_step(seed);
    strap = {1'b0, seed[18:16]};
    step(1);
  endtask

  task automatic wait_state(input agent_state_e target, input int limit);
    int n;
    n = 0;
    while ((ism_out != target) && (n < limit)) begin
      step(1);
      n++;
    end
    if (ism_out != target) begin
      timeouts++;
      $display("Timed out after %0d cycles waiting for ism_out %s", limit, target.name());
    end
  endtask

  task automatic wake_up();
    pick_delay();
    ip_wake = 1'b1;
    wait_state(AGENT_ACTIVEREQ, EXIT_WAIT);
    ip_wake = 1'b0;
  endtask

  // ====================
  // Sequence
  // ====================
  initial begin
    clk = 1'b0;
    rst_b = 1'b1;
    int_pok = 1'b0;                             // Held low so the timer loads first
    port_disable = 1'b0;
    side_ism_lock_b = 1'b1;
    side_clk_valid = 1'b1;
    ip_wake = 1'b0;
    idle = 1'b0;
    init_done = 1'b0;
    strap = '0;
    nak = 1'b0;
    stall = 1'b0;
    seed = LCG_SEED;
    #0.5;
    rst_b = 1'b0;                               // Asynchronous reset edge before the first clock
    step(RESET_CYCLES);
    rst_b = 1'b1;
    step(2);

    // Credit init after reset
    pick_delay();
    int_pok = 1'b1;
    init_done = 1'b1;
    wait_state(AGENT_CREDITREQ, EXIT_WAIT);
    wait_state(AGENT_CREDITINIT, STEP_WAIT);
    wait_state(AGENT_CREDITDONE, STEP_WAIT);
    wait_state(AGENT_IDLE, STEP_WAIT);

    // Wake and idle, a few delays and idle lengths
    repeat (3) begin
      wake_up();
      wait_state(AGENT_ACTIVE, STEP_WAIT);
      seed = lcg_step(seed);
      step(int'(seed[19:16]) + 2);
      idle = 1'b1;
      wait_state(AGENT_IDLEREQ, STEP_WAIT);
      wait_state(AGENT_IDLE, STEP_WAIT);
      idle = 1'b0;
    end

    // Idle NAK keeps the link up
    nak = 1'b1;
    wake_up();
    wait_state(AGENT_ACTIVE, STEP_WAIT);
    idle = 1'b1;
    wait_state(AGENT_IDLEREQ, STEP_WAIT);
    step(12);                                   // Several refused requests
    idle = 1'b0;
    wait_state(AGENT_ACTIVE, STEP_WAIT);
    nak = 1'b0;
    idle = 1'b1;
    wait_state(AGENT_IDLEREQ, STEP_WAIT);
    wait_state(AGENT_IDLE, STEP_WAIT);
    idle = 1'b0;

    // Hold-offs with a random wake pattern
    port_disable = 1'b1;
    repeat (20) begin
      seed = lcg_step(seed);
      ip_wake = seed[24];
      step(1);
    end
    ip_wake = 1'b0;
    port_disable = 1'b0;
    side_ism_lock_b = 1'b0;
    repeat (20) begin
      seed = lcg_step(seed);
      ip_wake = seed[24];
      step(1);
    end
    ip_wake = 1'b0;
    side_ism_lock_b = 1'b1;
    step(2);

    // Power loss while the fabric stalls ACTIVEREQ
    stall = 1'b1;
    wake_up();
    step(3);
    int_pok = 1'b0;
    wait_state(AGENT_IDLE, STEP_WAIT);
    stall = 1'b0;
    int_pok = 1'b1;
    step(4);

    $display("Checks done, %0d assertion errors, %0d timeouts", errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== sb_agent_port.f ====
verilog/sb_ism_pkg.sv
verilog/cg_delay_timer.sv
verilog/sb_agent_ism.sv
verilog/sb_agent_port.sv
verif/fabric_ism_model.sv
verif/tb_sb_agent_port.sv

// ==== Makefile ====
# Verilator build and run for the agent sideband port testbench

VERILATOR ?= verilator
TOP       := tb_sb_agent_port
FILELIST  := sb_agent_port.f
VFLAGS    := --binary --assert -j 0 --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal, the status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf $(OBJ_DIR)
